// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    // base widths
    localparam int XLEN   = 32;
    localparam int ILEN_C = 16;

    // canonical words
    // addi x0,x0,0
    localparam logic [XLEN-1:0] INST_NOP     = 32'h0000_0013;
    localparam logic [XLEN-1:0] INST_ILLEGAL = '0;

    // major opcodes of the expanded forms
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // funct fields of addi / add
    localparam logic [2:0] F3_ADD_ADDI = 3'b000;
    localparam logic [6:0] F7_ADD      = 7'b0000000;

    // quadrant in bits [1:0]
    localparam logic [1:0] QUAD_C1   = 2'b01;
    localparam logic [1:0] QUAD_C2   = 2'b10;
    localparam logic [1:0] QUAD_NONC = 2'b11;

    // compressed funct3 in bits [15:13]
    localparam logic [2:0] C_F3_ADDI  = 3'b000;
    localparam logic [2:0] C_F3_LI    = 3'b010;
    // c.mv / c.add share funct3, bit 12 tells them apart
    localparam logic [2:0] C_F3_MVADD = 3'b100;

    // supported compressed forms
    typedef enum logic [2:0] {
        C_ADDI,
        C_LI,
        C_MV,
        C_ADD,
        C_UNSUP
    } c_op_e;

endpackage

// ==== ifu_pkg.sv ====
package ifu_pkg;

    // trap bus layout, shared with later stages
    localparam int TRAP_LEN = 16;

    localparam int TRAP_INST_ADDR_MISALIGNED = 0;
    localparam int TRAP_INST_ACCESS_FAULT    = 1;
    localparam int TRAP_INST_PAGE_FAULT      = 12;

    typedef logic [TRAP_LEN-1:0] trap_bus_t;

    // pc step for a split instruction, one halfword
    localparam int PC_STEP_HALF = 2;

    // aligner fsm
    // wait_high holds the low half of a split 32-bit instruction
    typedef enum logic {
        ALIGN_IDLE,
        ALIGN_WAIT_HIGH
    } aligner_state_e;

endpackage

// ==== fetch_if.sv ====
`timescale 1ns/1ns

interface fetch_if;
    import rv_isa_pkg::*;

    // per-cycle qualifier, no back-pressure
    logic            valid;
    // raw word, compressed sits in the low half
    logic [XLEN-1:0] instr;
    logic            is_compressed;
    // pc of the first byte of the instruction
    logic [XLEN-1:0] addr;

    modport src (
        output valid, instr, is_compressed, addr
    );

    modport dst (
        input valid, instr, is_compressed, addr
    );

endinterface

// ==== halfword_aligner.sv ====
`timescale 1ns/1ns

module halfword_aligner (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  logic [rv_isa_pkg::XLEN-1:0] inst_addr_i,
    input  logic                        rdata_valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0] rdata_i,
    output logic                        ram_stall_o,
    output logic                        pc_step_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0] pc_step_addr_o,
    fetch_if.src                        out_if
);
    import rv_isa_pkg::*;
    import ifu_pkg::*;

    aligner_state_e    state;
    logic [ILEN_C-1:0] cur_half;
    logic              cur_is_c;
    logic              split_start;
    logic [ILEN_C-1:0] saved_half;
    logic [XLEN-1:0]   saved_pc;

    // halfword picked by pc bit 1
    assign cur_half = inst_addr_i[1] ? rdata_i[XLEN-1:ILEN_C] : rdata_i[ILEN_C-1:0];

    // anything but 2'b11 in the low bits is compressed
    assign cur_is_c = (cur_half[1:0] != QUAD_NONC);

    // 32-bit instruction starting in the upper half
    assign split_start = (state == ALIGN_IDLE) && rdata_valid_i && !cur_is_c
                         && inst_addr_i[1];

    // fsm and step pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= ALIGN_IDLE;
            pc_step_valid_o <= 1'b0;
        end else if (flush_i) begin
            state           <= ALIGN_IDLE;
            pc_step_valid_o <= 1'b0;
        end else begin
            // single-cycle request to the pc
            pc_step_valid_o <= split_start;
            case (state)
                ALIGN_IDLE: begin
                    if (split_start) begin
                        state <= ALIGN_WAIT_HIGH;
                    end
                end
                ALIGN_WAIT_HIGH: begin
                    // any valid word carries the high half, pc may or may not have held
                    if (rdata_valid_i) begin
                        state <= ALIGN_IDLE;
                    end
                end
                default: begin
                    state <= ALIGN_IDLE;
                end
            endcase
        end
    end

    // low half of the split instruction and its pc
    always_ff @(posedge clk) begin
        if (split_start) begin
            saved_half     <= cur_half;
            saved_pc       <= inst_addr_i;
            pc_step_addr_o <= inst_addr_i + XLEN'(PC_STEP_HALF);
        end
    end

    // output selection
    always_comb begin
        out_if.valid         = 1'b0;
        out_if.instr         = INST_NOP;
        out_if.is_compressed = 1'b0;
        out_if.addr          = inst_addr_i;
        if (state == ALIGN_WAIT_HIGH) begin
            out_if.addr = saved_pc;
            if (rdata_valid_i) begin
                // stitch new low half above the saved one
                out_if.valid = 1'b1;
                out_if.instr = {rdata_i[ILEN_C-1:0], saved_half};
            end
        end else if (rdata_valid_i) begin
            if (cur_is_c) begin
                out_if.valid         = 1'b1;
                out_if.instr         = {{ILEN_C{1'b0}}, cur_half};
                out_if.is_compressed = 1'b1;
            end else if (!inst_addr_i[1]) begin
                // aligned 32-bit, pass through
                out_if.valid = 1'b1;
                out_if.instr = rdata_i;
            end
        end
    end

    // stall while waiting for data, or when valid data issues nothing
    assign ram_stall_o = ((state == ALIGN_WAIT_HIGH) && !rdata_valid_i)
                         || (rdata_valid_i && !out_if.valid);

endmodule

// ==== rvc_expander.sv ====
`timescale 1ns/1ns

module rvc_expander (
    input  logic [rv_isa_pkg::ILEN_C-1:0] c_inst_i,
    output logic [rv_isa_pkg::XLEN-1:0]   exp_inst_o
);
    import rv_isa_pkg::*;

    c_op_e       c_op;
    logic [1:0]  quad;
    logic [2:0]  c_f3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] imm;

    // field split
    assign quad = c_inst_i[1:0];
    assign c_f3 = c_inst_i[15:13];
    // rd doubles as rs1 for addi / add
    assign rd   = c_inst_i[11:7];
    assign rs2  = c_inst_i[6:2];

    // six-bit immediate, sign bit in [12]
    assign imm = {{6{c_inst_i[12]}}, c_inst_i[12], c_inst_i[6:2]};

    // decode into a form
    always_comb begin
        c_op = C_UNSUP;
        case (quad)
            QUAD_C1: begin
                if (c_f3 == C_F3_ADDI) begin
                    c_op = C_ADDI;
                end else if (c_f3 == C_F3_LI) begin
                    c_op = C_LI;
                end
            end
            QUAD_C2: begin
                // rs2 of zero is jr / jalr / ebreak, not handled here
                if ((c_f3 == C_F3_MVADD) && (rs2 != 5'd0)) begin
                    if (c_inst_i[12]) begin
                        c_op = C_ADD;
                    end else begin
                        c_op = C_MV;
                    end
                end
            end
            default: begin
                c_op = C_UNSUP;
            end
        endcase
    end

    // build the 32-bit equivalent
    always_comb begin
        case (c_op)
            C_ADDI: begin
                // addi rd,rd,imm
                exp_inst_o = {imm, rd, F3_ADD_ADDI, rd, OPC_OP_IMM};
            end
            C_LI: begin
                // addi rd,x0,imm
                exp_inst_o = {imm, 5'd0, F3_ADD_ADDI, rd, OPC_OP_IMM};
            end
            C_MV: begin
                // add rd,x0,rs2
                exp_inst_o = {F7_ADD, rs2, 5'd0, F3_ADD_ADDI, rd, OPC_OP};
            end
            C_ADD: begin
                // add rd,rd,rs2
                exp_inst_o = {F7_ADD, rs2, rd, F3_ADD_ADDI, rd, OPC_OP};
            end
            default: begin
                // all zeros decodes as illegal downstream
                exp_inst_o = INST_ILLEGAL;
            end
        endcase
    end

endmodule

// ==== fetch_issue.sv ====
`timescale 1ns/1ns

module fetch_issue (
    fetch_if.dst                        in_if,
    input  logic                        page_fault_i,
    input  logic                        fault_valid_i,
    output logic [rv_isa_pkg::XLEN-1:0] inst_data_o,
    output logic [rv_isa_pkg::XLEN-1:0] inst_addr_o,
    output logic                        is_compressed_o,
    output ifu_pkg::trap_bus_t          trap_bus_o
);
    import rv_isa_pkg::*;
    import ifu_pkg::*;

    logic [XLEN-1:0] exp_inst;

    // expander always sees the low half
    rvc_expander u_rvc_expander (
        .c_inst_i   (in_if.instr[ILEN_C-1:0]),
        .exp_inst_o (exp_inst)
    );

    // bubble as nop when nothing issues
    always_comb begin
        if (!in_if.valid) begin
            inst_data_o = INST_NOP;
        end else if (in_if.is_compressed) begin
            inst_data_o = exp_inst;
        end else begin
            inst_data_o = in_if.instr;
        end
    end

    assign inst_addr_o     = in_if.addr;
    assign is_compressed_o = in_if.is_compressed;

    // only the page fault bit is sourced here
    always_comb begin
        trap_bus_o = '0;
        trap_bus_o[TRAP_INST_PAGE_FAULT] = page_fault_i & fault_valid_i;
    end

endmodule

// ==== ifu_top.sv ====
`timescale 1ns/1ns

module ifu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    // fetch request and memory response
    input  logic [rv_isa_pkg::XLEN-1:0] inst_addr_i,
    input  logic                        rdata_valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0] rdata_i,
    // page fault from translation
    input  logic                        page_fault_i,
    input  logic                        fault_valid_i,
    // to pc
    output logic                        ram_stall_o,
    output logic                        pc_step_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0] pc_step_addr_o,
    // to decode
    output logic [rv_isa_pkg::XLEN-1:0] inst_data_o,
    output logic [rv_isa_pkg::XLEN-1:0] inst_addr_o,
    output logic                        is_compressed_o,
    output ifu_pkg::trap_bus_t          trap_bus_o
);

    // realigned instruction between the two halves
    fetch_if u_fetch_if ();

    halfword_aligner u_halfword_aligner (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .inst_addr_i     (inst_addr_i),
        .rdata_valid_i   (rdata_valid_i),
        .rdata_i         (rdata_i),
        .ram_stall_o     (ram_stall_o),
        .pc_step_valid_o (pc_step_valid_o),
        .pc_step_addr_o  (pc_step_addr_o),
        .out_if          (u_fetch_if.src)
    );

    // expansion and trap bus
    fetch_issue u_fetch_issue (
        .in_if           (u_fetch_if.dst),
        .page_fault_i    (page_fault_i),
        .fault_valid_i   (fault_valid_i),
        .inst_data_o     (inst_data_o),
        .inst_addr_o     (inst_addr_o),
        .is_compressed_o (is_compressed_o),
        .trap_bus_o      (trap_bus_o)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 2;

    // free-running 4 ns clock
    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset held for two full cycles, drops on a falling edge
    initial begin
        rst_o = 1'b1;
        #(2 * HALF_PERIOD * RESET_CYCLES);
        rst_o = 1'b0;
    end

endmodule

// ==== tb_ifu.sv ====
`timescale 1ns/1ns

module tb_ifu;
    import rv_isa_pkg::*;
    import ifu_pkg::*;

    localparam int RESET_TIMEOUT = 20;
    localparam int NUM_RANDOM    = 20;

    // one table row, stimulus first, then expected outputs
    typedef struct packed {
        logic            flush;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] rdata;
        logic            valid;
        logic            pf;
        logic            fv;
        logic [XLEN-1:0] exp_data;
        logic [XLEN-1:0] exp_addr;
        logic            exp_c;
        logic            exp_stall;
        logic            exp_step;
        logic [XLEN-1:0] exp_step_addr;
        logic            exp_trap;
    } row_t;

    logic            clk;
    logic            rst;
    logic            flush;
    logic [XLEN-1:0] inst_addr;
    logic            rdata_valid;
    logic [XLEN-1:0] rdata;
    logic            page_fault;
    logic            fault_valid;
    logic            ram_stall;
    logic            pc_step_valid;
    logic [XLEN-1:0] pc_step_addr;
    logic [XLEN-1:0] inst_data;
    logic [XLEN-1:0] inst_addr_out;
    logic            is_compressed;
    trap_bus_t       trap_bus;

    row_t   rows[$];
    integer seed;
    int     errors;
    int     row_count;

    tb_clock_gen u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    ifu_top dut (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush),
        .inst_addr_i     (inst_addr),
        .rdata_valid_i   (rdata_valid),
        .rdata_i         (rdata),
        .page_fault_i    (page_fault),
        .fault_valid_i   (fault_valid),
        .ram_stall_o     (ram_stall),
        .pc_step_valid_o (pc_step_valid),
        .pc_step_addr_o  (pc_step_addr),
        .inst_data_o     (inst_data),
        .inst_addr_o     (inst_addr_out),
        .is_compressed_o (is_compressed),
        .trap_bus_o      (trap_bus)
    );

    // expected expansion, straight from the compressed-form rules
    function automatic logic [XLEN-1:0] ref_expand(input logic [15:0] c);
        logic [4:0]      rd;
        logic [4:0]      rs2;
        logic [11:0]     imm;
        logic [XLEN-1:0] word;
        rd   = c[11:7];
        rs2  = c[6:2];
        imm  = {{7{c[12]}}, c[6:2]};
        word = 32'h0;
        if (c[1:0] == 2'b01 && c[15:13] == 3'b000) begin
            word = {imm, rd, 3'b000, rd, OPC_OP_IMM};
        end else if (c[1:0] == 2'b01 && c[15:13] == 3'b010) begin
            word = {imm, 5'd0, 3'b000, rd, OPC_OP_IMM};
        end else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && rs2 != 5'd0) begin
            // bit 12 picks add over mv
            word = {7'd0, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, OPC_OP};
        end
        return word;
    endfunction

    task automatic report_mismatch(input string name, input int idx,
                                   input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        errors++;
        $display("CHECK FAILED row %0d %s got %h expected %h", idx, name, got, exp);
    endtask

    // drive on the falling edge, check before the next rising edge
    task automatic apply_row(input row_t r, input int idx);
        logic [XLEN-1:0] exp_trap_bus;
        @(negedge clk);
        flush       = r.flush;
        inst_addr   = r.addr;
        rdata       = r.rdata;
        rdata_valid = r.valid;
        page_fault  = r.pf;
        fault_valid = r.fv;
        #1;
        row_count++;
        exp_trap_bus = 32'(r.exp_trap) << TRAP_INST_PAGE_FAULT;
        if (inst_data !== r.exp_data) begin
            report_mismatch("inst_data_o", idx, inst_data, r.exp_data);
        end
        if (inst_addr_out !== r.exp_addr) begin
            report_mismatch("inst_addr_o", idx, inst_addr_out, r.exp_addr);
        end
        if (is_compressed !== r.exp_c) begin
            report_mismatch("is_compressed_o", idx, 32'(is_compressed), 32'(r.exp_c));
        end
        if (ram_stall !== r.exp_stall) begin
            report_mismatch("ram_stall_o", idx, 32'(ram_stall), 32'(r.exp_stall));
        end
        if (pc_step_valid !== r.exp_step) begin
            report_mismatch("pc_step_valid_o", idx, 32'(pc_step_valid), 32'(r.exp_step));
        end
        if (r.exp_step && pc_step_addr !== r.exp_step_addr) begin
            report_mismatch("pc_step_addr_o", idx, pc_step_addr, r.exp_step_addr);
        end
        if (32'(trap_bus) !== exp_trap_bus) begin
            report_mismatch("trap_bus_o", idx, 32'(trap_bus), exp_trap_bus);
        end
    endtask

    // columns: flush addr rdata valid pf fv | data addr c stall step step_addr trap
    task automatic load_table();
        // aligned 32-bit passes through
        rows.push_back({1'b0, 32'h0000_0100, 32'h00A0_0093, 1'b1, 1'b0, 1'b0,
                        32'h00A0_0093, 32'h0000_0100, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0});
        // c.addi x5,3 low, c.li x10,-1 high
        rows.push_back({1'b0, 32'h0000_0104, 32'h557D_028D, 1'b1, 1'b0, 1'b0,
                        32'h0032_8293, 32'h0000_0104, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0});
        rows.push_back({1'b0, 32'h0000_0106, 32'h557D_028D, 1'b1, 1'b0, 1'b0,
                        32'hFFF0_0513, 32'h0000_0106, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0});
        // c.mv x8,x9 low, c.add x1,x2 high
        rows.push_back({1'b0, 32'h0000_0108, 32'h908A_8426, 1'b1, 1'b0, 1'b0,
                        32'h0090_0433, 32'h0000_0108, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0});
        rows.push_back({1'b0, 32'h0000_010A, 32'h908A_8426, 1'b1, 1'b0, 1'b0,
                        32'h0020_80B3, 32'h0000_010A, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0});
        // c.lw unsupported, then c.jr (mv with rs2 zero)
        rows.push_back({1'b0, 32'h0000_010C, 32'h8402_4188, 1'b1, 1'b0, 1'b0,
                        32'h0000_0000, 32'h0000_010C, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0});
        rows.push_back({1'b0, 32'h0000_010E, 32'h8402_4188, 1'b1, 1'b0, 1'b0,
                        32'h0000_0000, 32'h0000_010E, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0});
        // split add x3,x1,x2 from 0x112, two empty cycles, then the high half
        rows.push_back({1'b0, 32'h0000_0112, 32'h81B3_0001, 1'b1, 1'b0, 1'b0,
                        INST_NOP, 32'h0000_0112, 1'b0, 1'b1, 1'b0, 32'h0, 1'b0});
        rows.push_back({1'b0, 32'h0000_0114, 32'h0000_0000, 1'b0, 1'b0, 1'b0,
                        INST_NOP, 32'h0000_0112, 1'b0, 1'b1, 1'b1, 32'h0000_0114, 1'b0});
        rows.push_back({1'b0, 32'h0000_0114, 32'h0000_0000, 1'b0, 1'b0, 1'b0,
                        INST_NOP, 32'h0000_0112, 1'b0, 1'b1, 1'b0, 32'h0, 1'b0});
        rows.push_back({1'b0, 32'h0000_0114, 32'hABCD_0020, 1'b1, 1'b0, 1'b0,
                        32'h0020_81B3, 32'h0000_0112, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0});
        // page fault needs both inputs
        rows.push_back({1'b0, 32'h0000_0118, 32'h00A0_0093, 1'b1, 1'b1, 1'b1,
                        32'h00A0_0093, 32'h0000_0118, 1'b0, 1'b0, 1'b0, 32'h0, 1'b1});
        rows.push_back({1'b0, 32'h0000_011C, 32'h00C0_0113, 1'b1, 1'b1, 1'b0,
                        32'h00C0_0113, 32'h0000_011C, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0});
        rows.push_back({1'b0, 32'h0000_0120, 32'h557D_028D, 1'b1, 1'b0, 1'b1,
                        32'h0032_8293, 32'h0000_0120, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0});
        // split start, flush while waiting, next aligned word is clean
        rows.push_back({1'b0, 32'h0000_0122, 32'h81B3_0001, 1'b1, 1'b0, 1'b0,
                        INST_NOP, 32'h0000_0122, 1'b0, 1'b1, 1'b0, 32'h0, 1'b0});
        rows.push_back({1'b1, 32'h0000_0124, 32'h0000_0000, 1'b0, 1'b0, 1'b0,
                        INST_NOP, 32'h0000_0122, 1'b0, 1'b1, 1'b1, 32'h0000_0124, 1'b0});
        rows.push_back({1'b0, 32'h0000_0200, 32'h00A0_0093, 1'b1, 1'b0, 1'b0,
                        32'h00A0_0093, 32'h0000_0200, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0});
        // idle with no data, no stall
        rows.push_back({1'b0, 32'h0000_0204, 32'h0000_0000, 1'b0, 1'b0, 1'b0,
                        INST_NOP, 32'h0000_0204, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0});
    endtask

    task automatic run_random();
        logic [31:0]     r1;
        logic [31:0]     r2;
        logic [15:0]     word;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] word_pair;
        row_t            rr;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r1   = $random(seed);
            r2   = $random(seed);
            word = r1[15:0];
            // bias toward the supported forms
            case (r1[17:16])
                2'd0: word = {3'b000, word[12:2], 2'b01};
                2'd1: word = {3'b010, word[12:2], 2'b01};
                2'd2: word = {3'b100, word[12:2], 2'b10};
                default: word[1:0] = (word[1:0] == 2'b11) ? 2'b00 : word[1:0];
            endcase
            // alternate halfwords
            addr      = 32'h0000_0300 + 32'(2 * i);
            word_pair = addr[1] ? {word, r2[15:0]} : {r2[15:0], word};
            rr = {1'b0, addr, word_pair, 1'b1, 1'b0, 1'b0,
                  ref_expand(word), addr, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0};
            apply_row(rr, rows.size() + i);
        end
    endtask

    initial begin
        int wait_cycles;
        flush       = 1'b0;
        inst_addr   = '0;
        rdata       = '0;
        rdata_valid = 1'b0;
        page_fault  = 1'b0;
        fault_valid = 1'b0;
        seed        = 32'h875c_5e76;
        errors      = 0;
        row_count   = 0;
        wait_cycles = 0;
        load_table();
        while (rst !== 1'b0 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst !== 1'b0) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Test failures found");
        end else begin
            foreach (rows[i]) begin
                apply_row(rows[i], i);
            end
            run_random();
            $display("rows checked %0d, errors %0d", row_count, errors);
            if (errors == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
        end
        $finish;
    end

endmodule

// ==== files.f ====
rv_isa_pkg.sv
ifu_pkg.sv
fetch_if.sv
halfword_aligner.sv
rvc_expander.sv
fetch_issue.sv
ifu_top.sv
tb_clock_gen.sv
tb_ifu.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ns --top-module tb_ifu -f files.f \
    -o sim_ifu || exit 1
sim_out=$(./obj_dir/sim_ifu)
echo "$sim_out"
echo "$sim_out" | grep -q 'All tests passed!' && exit 0 || exit 1
